// ==== Makefile ====
# Verilator build and run of the I2S receive testbench

VERILATOR ?= verilator
TOP       ?= i2si_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test OK
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
EXTRA     ?=

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hw/i2si_deserializer.sv ====
module i2si_deserializer
	import i2si_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        en,
	input  i2si_pins_t  pins,
	input  logic        sck_rise,
	output i2si_frame_t frame,
	output logic        push
);

	deser_state_t state;
	deser_state_t state_next;
	logic         ws_prev; // ws at previous sck rise
	logic         boundary; // ws changed at this sck rise
	logic         right_done; // boundary closing a right word
	bit_cnt_t     bit_cnt; // bits shifted since last boundary
	bit_cnt_t     cnt_next;
	sample_t      shreg; // right aligned partial word
	sample_t      word_next; // shreg including current bit
	sample_t      word_aligned; // msb aligned, zero filled
	sample_t      left_q; // last committed left word
	sample_t      right_q; // last committed right word

	// bit sampled at a boundary still belongs to the old channel
	assign boundary   = sck_rise && (pins.ws != ws_prev);
	assign right_done = boundary && ws_prev; // old ws high means right

	// shift in sd until the word is full, extra bits ignored
	always_comb
	begin
		if (bit_cnt < SAMPLE_CNT)
		begin
			word_next = {shreg[SAMPLE_W-2:0], pins.sd};
			cnt_next  = bit_cnt + 1'b1;
		end
		else
		begin
			word_next = shreg; // hold, word already complete
			cnt_next  = bit_cnt;
		end
		// short word gets zero lsbs
		word_aligned = word_next << (SAMPLE_CNT - cnt_next);
	end

	// enable and left alignment
	always_comb
	begin
		state_next = state;
		unique case (state)
			IDLE:
			begin
				if (en)
					state_next = WAIT_LEFT;
			end
			WAIT_LEFT:
			begin
				if (!en)
					state_next = IDLE;
				else if (right_done)
					state_next = RUN; // next bit is left msb
			end
			RUN:
			begin
				if (!en)
					state_next = IDLE;
			end
			default:
				state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state   <= IDLE;
			ws_prev <= 1'b0;
			bit_cnt <= '0;
			shreg   <= '0;
			push    <= 1'b0;
		end
		else
		begin
			state <= state_next;
			push  <= 1'b0; // single clk pulse
			// ws tracked even when disabled, so first boundary after enable is genuine
			if (sck_rise)
				ws_prev <= pins.ws;
			if (state == IDLE || !en)
			begin
				bit_cnt <= '0;
				shreg   <= '0;
			end
			else if (sck_rise)
			begin
				if (boundary)
				begin
					bit_cnt <= '0; // next rise is msb of new channel
					shreg   <= '0;
					push    <= (state == RUN) && ws_prev; // pair done at right to left
				end
				else
				begin
					bit_cnt <= cnt_next;
					shreg   <= word_next;
				end
			end
		end
	end

	// commit finished word to its channel
	always_ff @(posedge clk)
	begin
		if (en && state != IDLE && boundary)
		begin
			if (ws_prev)
				right_q <= word_aligned;
			else
				left_q <= word_aligned;
		end
	end

	// left_q stays until the next left to right boundary, well after push
	assign frame = '{left: left_q, right: right_q};

endmodule

// ==== hw/i2si_frame_fifo.sv ====
module i2si_frame_fifo
	import i2si_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        en,
	input  logic        push,
	input  i2si_frame_t frame,
	output i2si_frame_t out_frame,
	output logic        out_valid,
	input  logic        out_ready,
	output logic        overflow
);

	i2si_frame_t mem [FIFO_DEPTH]; // frame storage
	fifo_ptr_t   wr_ptr;
	fifo_ptr_t   rd_ptr;
	fifo_cnt_t   count; // frames stored
	fifo_cnt_t   count_next;
	logic        valid_q; // registered not empty
	logic        overflow_q; // sticky drop flag
	logic        full;
	logic        pop; // handshake on output
	logic        wr_en; // push that is stored
	logic        drop; // push that is lost

	assign full  = (count == FIFO_FULL);
	assign pop   = valid_q && out_ready;
	assign wr_en = push && (!full || pop); // full plus pop frees a slot this cycle
	assign drop  = push && full && !pop;

	always_comb
	begin
		unique case ({wr_en, pop})
			2'b10:
				count_next = count + 1'b1;
			2'b01:
				count_next = count - 1'b1;
			default:
				count_next = count; // idle or push with pop
		endcase
	end

	// pointers wrap on their own width
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			valid_q <= 1'b0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count   <= count_next;
			valid_q <= (count_next != '0); // one clk after push into empty
		end
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			overflow_q <= 1'b0;
		else if (!en)
			overflow_q <= 1'b0; // cleared by disable only
		else if (drop)
			overflow_q <= 1'b1;
	end

	// slot at wr_ptr never holds an unread frame when written
	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_ptr] <= frame;
	end

	assign out_frame = mem[rd_ptr]; // head, stable until popped
	assign out_valid = valid_q;
	assign overflow  = overflow_q;

endmodule

// ==== hw/i2si_pin_sync.sv ====
module i2si_pin_sync
	import i2si_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       sck,
	input  logic       ws,
	input  logic       sd,
	output i2si_pins_t pins,
	output logic       sck_rise
);

	i2si_pins_t sync1; // first stage, may go metastable
	i2si_pins_t sync2; // second stage, safe to use
	logic       sck_d; // sync2.sck one clk later
	logic       sck_rise_q; // registered edge pulse

	// two flops per pin, all three sampled together
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			sync1 <= '0;
			sync2 <= '0;
		end
		else
		begin
			sync1 <= '{sck: sck, ws: ws, sd: sd}; // raw async pins
			sync2 <= sync1;
		end
	end

	// rising edge of sck seen in clk domain
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			sck_d      <= 1'b0;
			sck_rise_q <= 1'b0;
		end
		else
		begin
			sck_d      <= sync2.sck;
			sck_rise_q <= sync2.sck & ~sck_d; // high for one clk per sck rise
		end
	end

	assign pins     = sync2; // 2 clk after the pin
	assign sck_rise = sck_rise_q; // 3 clk after the sck pin edge

endmodule

// ==== hw/i2si_pkg.sv ====
package i2si_pkg;

	// word and frame sizes
	localparam int SAMPLE_W = 16; // bits per channel word
	localparam int CNT_W    = $clog2(SAMPLE_W) + 1; // counts 0..SAMPLE_W

	// frame buffer
	localparam int FIFO_DEPTH = 4; // stereo frames held
	localparam int FIFO_AW    = $clog2(FIFO_DEPTH); // pointer bits, depth is a power of two

	typedef logic [SAMPLE_W-1:0] sample_t; // one audio sample
	typedef logic [CNT_W-1:0]    bit_cnt_t; // bits received in current word
	typedef logic [FIFO_AW-1:0]  fifo_ptr_t; // read or write slot
	typedef logic [FIFO_AW:0]    fifo_cnt_t; // occupancy, needs one extra bit

	localparam bit_cnt_t  SAMPLE_CNT = bit_cnt_t'(SAMPLE_W); // count at a full word
	localparam fifo_cnt_t FIFO_FULL  = fifo_cnt_t'(FIFO_DEPTH); // occupancy when full

	// one stereo frame, left in the upper half
	typedef struct packed
	{
		sample_t left;
		sample_t right;
	} i2si_frame_t;

	// synchronized pin levels
	typedef struct packed
	{
		logic sck;
		logic ws; // low left, high right
		logic sd;
	} i2si_pins_t;

	// deserializer control
	typedef enum logic [1:0]
	{
		IDLE,      // disabled, counters held clear
		WAIT_LEFT, // enabled, waiting for right to left boundary
		RUN        // aligned, pushing frames
	} deser_state_t;

endpackage

// ==== hw/i2si_rx_top.sv ====
module i2si_rx_top
	import i2si_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        sck,
	input  logic        ws,
	input  logic        sd,
	input  logic        rf_i2si_en,
	output i2si_frame_t out_frame,
	output logic        out_valid,
	input  logic        out_ready,
	output logic        overflow
);

	i2si_pins_t  pins; // synchronized sck, ws, sd
	logic        sck_rise; // one clk per serial clock rise
	i2si_frame_t frame; // assembled stereo pair
	logic        push; // frame strobe into fifo

	i2si_pin_sync u_sync (
		.clk      (clk),
		.rst      (rst),
		.sck      (sck),
		.ws       (ws),
		.sd       (sd),
		.pins     (pins),
		.sck_rise (sck_rise)
	);

	i2si_deserializer u_deser (
		.clk      (clk),
		.rst      (rst),
		.en       (rf_i2si_en),
		.pins     (pins),
		.sck_rise (sck_rise),
		.frame    (frame),
		.push     (push)
	);

	i2si_frame_fifo u_fifo (
		.clk       (clk),
		.rst       (rst),
		.en        (rf_i2si_en),
		.push      (push),
		.frame     (frame),
		.out_frame (out_frame),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.overflow  (overflow)
	);

endmodule

// ==== src.f ====
hw/i2si_pkg.sv
hw/i2si_pin_sync.sv
hw/i2si_deserializer.sv
hw/i2si_frame_fifo.sv
hw/i2si_rx_top.sv
verification/i2si_tb_assert.sv
verification/i2si_tb.sv

// ==== verification/i2si_tb.sv ====
module i2si_tb
	import i2si_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_BIT = 8; // clk cycles per sck half period
	localparam int TIMEOUT  = 2000; // clk cycles allowed per wait
	localparam int RUN_MAX  = 200000; // whole run limit in clk cycles

	logic        clk;
	logic        rst;
	logic        sck;
	logic        ws;
	logic        sd;
	logic        rf_i2si_en;
	logic        out_ready;
	i2si_frame_t out_frame;
	logic        out_valid;
	logic        overflow;

	i2si_frame_t sb [$]; // frames still expected in arrival order
	int          err_cnt;
	int          chk_cnt;
	int          seed;

	i2si_rx_top u_i2si_rx_top (
		.clk        (clk),
		.rst        (rst),
		.sck        (sck),
		.ws         (ws),
		.sd         (sd),
		.rf_i2si_en (rf_i2si_en),
		.out_frame  (out_frame),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.overflow   (overflow)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 100 MHz system clock
	end

	task automatic check_word(input string name, input sample_t got, input sample_t want);
		chk_cnt++;
		if (got !== want)
		begin
			err_cnt++;
			$display("ERR %s got %h exp %h", name, got, want);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		chk_cnt++;
		if (got !== want)
		begin
			err_cnt++;
			$display("ERR %s got %h exp %h", name, got, want);
		end
	endtask

	task automatic note_failure(input string what);
		err_cnt++;
		$display("error: %s", what);
	endtask

	// one serial bit with ws and sd changed at the falling sck
	task automatic send_bit(input logic ws_val, input logic sd_val);
		@(negedge clk);
		sck = 1'b0;
		ws  = ws_val;
		sd  = sd_val;
		repeat (HALF_BIT) @(negedge clk);
		sck = 1'b1; // receiver samples on this rise
		repeat (HALF_BIT - 1) @(negedge clk);
	endtask

	task automatic send_word(input sample_t word, input logic ws_val);
		int i;
		for (i = SAMPLE_W - 1; i > 0; i--)
			send_bit(ws_val, word[i]); // msb first
		send_bit(!ws_val, word[0]); // ws flips one bit ahead of the next msb
	endtask

	task automatic send_frame(input sample_t left, input sample_t right);
		send_word(left, 1'b0);
		send_word(right, 1'b1);
	endtask

	task automatic send_expected(input sample_t left, input sample_t right);
		sb.push_back(i2si_frame_t'{left: left, right: right});
		send_frame(left, right);
	endtask

	// short disable then a dummy right word so the receiver sees right to left
	task automatic enable_stream();
		@(negedge clk);
		rf_i2si_en = 1'b0;
		repeat (4) @(negedge clk);
		rf_i2si_en = 1'b1;
		repeat (4) @(negedge clk);
		send_word('0, 1'b1); // never shows up as a frame
	endtask

	task automatic expect_frame(input bit rand_ready);
		int          waited;
		bit          got;
		i2si_frame_t want;
		waited = 0;
		got    = 1'b0;
		while (!got && waited < TIMEOUT)
		begin
			@(negedge clk);
			out_ready = rand_ready ? 1'($random(seed)) : 1'b1;
			if (out_valid && out_ready)
				got = 1'b1; // transfer on the coming rising edge
			waited++;
		end
		if (!got)
			note_failure("timeout waiting for out_valid");
		else if (sb.size() == 0)
			note_failure("frame received while none was expected");
		else
		begin
			want = sb.pop_front();
			check_word("out_frame.left", out_frame.left, want.left);
			check_word("out_frame.right", out_frame.right, want.right);
		end
	endtask

	task automatic drain(input int n, input bit rand_ready);
		int k;
		for (k = 0; k < n; k++)
			expect_frame(rand_ready);
		@(negedge clk);
		out_ready = 1'b0; // after last transfer edge
	endtask

	task automatic check_no_frame(input int cycles);
		int i;
		bit seen;
		seen = 1'b0;
		chk_cnt++;
		for (i = 0; i < cycles && !seen; i++)
		begin
			@(negedge clk);
			if (out_valid)
				seen = 1'b1;
		end
		if (seen)
			note_failure("unexpected frame on the output");
	endtask

	task automatic test_reset();
		int i;
		for (i = 0; i < 5; i++)
		begin
			@(negedge clk);
			check_bit("out_valid", out_valid, 1'b0);
			check_bit("overflow", overflow, 1'b0);
		end
		rst = 1'b1; // release after 5 cycles
		@(negedge clk);
		check_bit("out_valid", out_valid, 1'b0);
		check_bit("overflow", overflow, 1'b0);
		rf_i2si_en = 1'b1;
		check_no_frame(TIMEOUT); // no frame without serial activity
	endtask

	task automatic test_directed();
		sample_t left_tbl [4] = '{16'haaaa, 16'h0001, 16'h8000, 16'h1234};
		sample_t right_tbl [4] = '{16'hffff, 16'hffff, 16'h0001, 16'h5a5a};
		int      i;
		enable_stream();
		fork
			begin
				for (i = 0; i < 4; i++)
					send_expected(left_tbl[i], right_tbl[i]);
			end
			drain(4, 1'b0); // out_ready held high
		join
		check_no_frame(TIMEOUT / 2);
	endtask

	task automatic test_backpressure();
		int i;
		enable_stream();
		for (i = 0; i < 3; i++)
			send_expected(sample_t'($random(seed)), sample_t'($random(seed)));
		drain(3, 1'b0); // all three still queued
		check_no_frame(200);
		check_bit("overflow", overflow, 1'b0);
	endtask

	task automatic test_overflow();
		int      i;
		int      waited;
		sample_t l;
		sample_t r;
		enable_stream();
		for (i = 0; i < FIFO_DEPTH + 2; i++)
		begin
			l = sample_t'($random(seed));
			r = sample_t'($random(seed));
			if (i < FIFO_DEPTH)
				sb.push_back(i2si_frame_t'{left: l, right: r}); // later ones get dropped
			send_frame(l, r);
		end
		check_bit("overflow", overflow, 1'b1);
		drain(FIFO_DEPTH, 1'b0);
		check_no_frame(200);
		check_bit("overflow", overflow, 1'b1); // sticky while enabled
		rf_i2si_en = 1'b0;
		waited = 0;
		while (overflow && waited < TIMEOUT)
		begin
			@(negedge clk);
			waited++;
		end
		check_bit("overflow", overflow, 1'b0);
	endtask

	task automatic test_disable();
		@(negedge clk);
		rf_i2si_en = 1'b0;
		send_frame(16'h1111, 16'h2222); // ignored while disabled
		send_frame(16'h3333, 16'h4444);
		check_no_frame(200);
		enable_stream();
		send_expected(16'hc3c3, 16'h3c3c);
		drain(1, 1'b0);
		check_no_frame(200);
	endtask

	task automatic test_random();
		sample_t left_tbl [20];
		sample_t right_tbl [20];
		int      i;
		for (i = 0; i < 20; i++)
		begin
			left_tbl[i]  = sample_t'($random(seed)); // frame data drawn before the stream
			right_tbl[i] = sample_t'($random(seed));
		end
		enable_stream();
		fork
			begin
				for (i = 0; i < 20; i++)
					send_expected(left_tbl[i], right_tbl[i]);
			end
			drain(20, 1'b1); // out_ready toggles
		join
		check_no_frame(200);
		check_bit("overflow", overflow, 1'b0);
	endtask

	initial
	begin
		seed       = 32'hea36_6cc4;
		err_cnt    = 0;
		chk_cnt    = 0;
		rst        = 1'b0;
		sck        = 1'b0;
		ws         = 1'b0; // idle on left
		sd         = 1'b0;
		rf_i2si_en = 1'b0;
		out_ready  = 1'b0;
		test_reset();
		test_directed();
		test_backpressure();
		test_overflow();
		test_disable();
		test_random();
		err_cnt += u_i2si_rx_top.u_assert.fail_cnt; // bound assertion failures
		$display("checks %0d errors %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// guard against a stuck run
	initial
	begin
		repeat (RUN_MAX) @(posedge clk);
		$display("run limit reached, checks %0d errors %0d", chk_cnt, err_cnt);
		$display("Test FAILED");
		$finish;
	end

endmodule

// ==== verification/i2si_tb_assert.sv ====
module i2si_tb_assert
	import i2si_pkg::*;
(
	input logic        clk,
	input logic        rst,
	input logic        rf_i2si_en,
	input i2si_frame_t out_frame,
	input logic        out_valid,
	input logic        out_ready,
	input logic        overflow
);

	timeunit 1ns;
	timeprecision 100ps;

	int fail_cnt = 0; // failed assertions so far

	// nothing offered in reset
	valid_in_reset: assert property (@(posedge clk) !rst |-> !out_valid)
	else
	begin
		fail_cnt++;
		$error("out_valid high while in reset");
	end

	// stalled frame holds until taken
	hold_stable: assert property (@(posedge clk) disable iff (!rst)
		out_valid && !out_ready |=> out_valid && $stable(out_frame))
	else
	begin
		fail_cnt++;
		$error("out_valid or out_frame changed while stalled");
	end

	// only a disable clears the flag
	overflow_sticky: assert property (@(posedge clk) disable iff (!rst)
		$fell(overflow) |-> !$past(rf_i2si_en))
	else
	begin
		fail_cnt++;
		$error("overflow cleared while enabled");
	end

endmodule

bind i2si_rx_top i2si_tb_assert u_assert (
	.clk        (clk),
	.rst        (rst),
	.rf_i2si_en (rf_i2si_en),
	.out_frame  (out_frame),
	.out_valid  (out_valid),
	.out_ready  (out_ready),
	.overflow   (overflow)
);
